// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - src/ex_pkg.sv
  - src/mul_if.sv
  - src/alu.sv
  - src/int_multiplier.sv
  - src/ex_bypass.sv
  - src/ex_stage.sv
  - target: simulation
    files:
      - dv/ex_checker.sv
      - dv/ex_tb.sv

// ==== dv/ex_checker.sv ====
`timescale 1ns/1ps

module ex_checker
	import ex_pkg::*;
(
	input	logic			clk, reset, flush, valid_in, ready_out, valid_out, ready_in,
	input	logic	[31:0]	pc_id, imm_id, rs1_data_id, rs2_data_id, rd_data_mem,
	input	logic			rs1_rena_id, rs2_rena_id, rd_wena_id, rd_wena_mem,
	input	logic	[4:0]	rs1_addr_id, rs2_addr_id, rd_addr_id, rd_addr_mem,
	input	logic			sel_pc_id, sel_imm_id,
	input	wb_src_t		wb_src_id,
	input	alu_op_t		alu_op_id,
	input	mem_op_t		mem_op_id,
	input	mul_op_t		mul_op_id,
	input	logic			jump_ena_id, jump_ind_id, jump_alw_id, jump_pred_id,
	input	logic			rd_wena_ex, jump_taken_ex, jump_mpred_ex, exc_pend_ex,
	input	logic	[4:0]	rd_addr_ex,
	input	logic	[31:0]	rd_data_ex, jump_addr_ex, exc_cause_ex,
	input	logic	[31:0]	pc_ex,
	input	wb_src_t		wb_src_ex,
	input	mem_op_t		mem_op_ex,
	input	logic	[31:0]	axi_awaddr, axi_wdata, axi_araddr,
	input	logic	[2:0]	axi_awprot, axi_arprot,
	input	logic	[3:0]	axi_wstrb,
	input	logic			axi_awvalid, axi_awready, axi_wvalid, axi_wready,
	input	logic			axi_arvalid, axi_arready,
	output	int				errors
);

	typedef struct packed {
		logic	[2:0]	kind;
		logic	[31:0]	pc;
		logic	[2:0]	src;
		logic	[2:0]	mop;
		logic			wena;
		logic	[4:0]	rd;
		logic	[31:0]	data;
		logic			jt;
		logic			jm;
		logic	[31:0]	ja;
		logic			exc;
		logic	[31:0]	cause;
		logic			aw;
		logic			w;
		logic			ar;
		logic	[31:0]	addr;
		logic	[31:0]	wdata;
		logic	[3:0]	wstrb;
	} exp_t;

	exp_t			q[$];
	exp_t			e;
	logic			rec_w;
	logic	[4:0]	rec_a;
	logic	[31:0]	rec_d;
	wb_src_t		rec_src;
	logic			aw_p, w_p, ar_p, accepted, exp_valid;

	function automatic string kind_name(input logic [2:0] k);
		case (k)
			3'd1: return "mul";
			3'd2: return "jump";
			3'd3: return "store";
			3'd4: return "load";
			3'd5: return "misaligned";
			default: return "alu";
		endcase
	endfunction

	// youngest match first, x0 excluded
	function automatic logic [31:0] fwd(input logic en, input logic [4:0] a,
		input logic [31:0] rf, input logic [31:0] md);
		if (en && a != 0 && rec_w && a == rec_a)
			return rec_d;
		if (en && a != 0 && rd_wena_mem && a == rd_addr_mem)
			return md;
		return rf;
	endfunction

	function automatic exp_t predict(input logic [31:0] md);
		exp_t r;
		logic [31:0] s1, s2, a, b, y;
		logic [63:0] sa, sb, p;
		logic ml, ms, st, mem;
		s1 = fwd(rs1_rena_id, rs1_addr_id, rs1_data_id, md);
		s2 = fwd(rs2_rena_id, rs2_addr_id, rs2_data_id, md);
		a = sel_pc_id ? pc_id : s1;
		b = sel_imm_id ? imm_id : s2;
		case (alu_op_id)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_SLL: y = a << b[4:0];
			ALU_SRL: y = a >> b[4:0];
			ALU_SRA: y = $signed(a) >>> b[4:0];
			ALU_XOR: y = a ^ b;
			ALU_OR: y = a | b;
			ALU_AND: y = a & b;
			ALU_SLT, ALU_LT: y = {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU, ALU_LTU: y = {31'd0, a < b};
			ALU_GE: y = {31'd0, $signed(a) >= $signed(b)};
			ALU_GEU: y = {31'd0, a >= b};
			ALU_EQ: y = {31'd0, a == b};
			default: y = {31'd0, a != b};
		endcase
		sa = (mul_op_id == MUL_MULH || mul_op_id == MUL_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
		sb = (mul_op_id == MUL_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
		p = sa * sb;
		r = '0;
		r.pc = pc_id;
		r.src = wb_src_id;
		r.mop = mem_op_id;
		r.jt = jump_ena_id && (y[0] || jump_alw_id);
		r.jm = jump_ena_id && (jump_pred_id != r.jt);
		if (!r.jt)
			r.ja = pc_id + 4;
		else if (jump_ind_id)
			r.ja = (s1 + imm_id) & ~32'd1;
		else
			r.ja = pc_id + imm_id;
		mem = (wb_src_id == SEL_MEM);
		st = mem_op_id inside {MEM_SB, MEM_SH, MEM_SW};
		ml = mem && ((mem_op_id inside {MEM_LH, MEM_LHU} && y[0]) ||
			(mem_op_id == MEM_LW && y[1:0] != 0));
		ms = mem && ((mem_op_id == MEM_SH && y[0]) || (mem_op_id == MEM_SW && y[1:0] != 0));
		r.exc = (r.jt && r.ja[1:0] != 0) || ml || ms;
		r.cause = (r.jt && r.ja[1:0] != 0) ? 32'd0 : ml ? 32'd4 : ms ? 32'd6 : 32'd0;
		r.wena = rd_wena_id && !r.exc;
		r.rd = rd_addr_id;
		case (wb_src_id)
			SEL_MUL: r.data = (mul_op_id == MUL_MUL) ? p[31:0] : p[63:32];
			SEL_PC4: r.data = pc_id + 4;
			default: r.data = y;
		endcase
		r.aw = mem && st && !r.exc;
		r.w = r.aw;
		r.ar = mem && !st && !r.exc;
		r.addr = y;
		case (mem_op_id)
			MEM_SB: {r.wdata, r.wstrb} = {{4{s2[7:0]}}, 4'(4'd1 << y[1:0])};
			MEM_SH: {r.wdata, r.wstrb} = {{2{s2[15:0]}}, 4'(4'd3 << y[1:0])};
			default: {r.wdata, r.wstrb} = {s2, 4'(4'd15 << y[1:0])};
		endcase
		r.kind = r.exc ? 3'd5 : wb_src_id == SEL_MUL ? 3'd1 : jump_ena_id ? 3'd2 :
			(mem && st) ? 3'd3 : mem ? 3'd4 : 3'd0;
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("** Error %s expected %h actual %h", name, exp, act);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			q.delete();
			rec_w = 1'b0;
			{aw_p, w_p, ar_p} = 3'b000;
		end else begin
			// the stage holds at most one instruction
			exp_valid = (q.size() != 0) && !flush;
			check("valid_out", exp_valid, valid_out);
			if (exp_valid) begin
				e = q[0];
				check({kind_name(e.kind), " pc"}, e.pc, pc_ex);
				check({kind_name(e.kind), " wb_src"}, e.src, wb_src_ex);
				check({kind_name(e.kind), " mem_op"}, e.mop, mem_op_ex);
				check({kind_name(e.kind), " rd_wena"}, e.wena, rd_wena_ex);
				check({kind_name(e.kind), " rd_addr"}, e.rd, rd_addr_ex);
				check({kind_name(e.kind), " rd_data"}, e.data, rd_data_ex);
				check({kind_name(e.kind), " taken"}, e.jt, jump_taken_ex);
				check({kind_name(e.kind), " mispredict"}, e.jm, jump_mpred_ex);
				check({kind_name(e.kind), " target"}, e.ja, jump_addr_ex);
				check({kind_name(e.kind), " exc_pend"}, e.exc, exc_pend_ex);
				check({kind_name(e.kind), " exc_cause"}, e.cause, exc_cause_ex);
				if (e.aw) begin
					check({kind_name(e.kind), " awaddr"}, e.addr, axi_awaddr);
					check({kind_name(e.kind), " awprot"}, 3'b010, axi_awprot);
				end
				if (e.w) begin
					check({kind_name(e.kind), " wdata"}, e.wdata, axi_wdata);
					check({kind_name(e.kind), " wstrb"}, e.wstrb, axi_wstrb);
				end
				if (e.ar) begin
					check({kind_name(e.kind), " araddr"}, e.addr, axi_araddr);
					check({kind_name(e.kind), " arprot"}, 3'b010, axi_arprot);
				end
			end
			check("awvalid", aw_p && exp_valid, axi_awvalid);
			check("wvalid", w_p && exp_valid, axi_wvalid);
			check("arvalid", ar_p && exp_valid, axi_arvalid);
			if (aw_p && exp_valid && axi_awready)
				aw_p = 1'b0;
			if (w_p && exp_valid && axi_wready)
				w_p = 1'b0;
			if (ar_p && exp_valid && axi_arready)
				ar_p = 1'b0;
			if (exp_valid && ready_in)
				void'(q.pop_front());
			accepted = valid_in && ready_out;
			// load in EX with a dependent source
			if (accepted && rec_w && rec_src == SEL_MEM && rec_a != 0 &&
				((rs1_rena_id && rs1_addr_id == rec_a) || (rs2_rena_id && rs2_addr_id == rec_a))) begin
				errors++;
				$display("dependent instruction accepted while a load was in EX");
			end
			if (flush) begin
				q.delete();
				rec_w = 1'b0;
				{aw_p, w_p, ar_p} = 3'b000;
			end else if (accepted) begin
				e = predict(rd_data_mem);
				q.push_back(e);
				rec_w = e.wena;
				rec_a = e.rd;
				rec_d = e.data;
				rec_src = wb_src_id;
				{aw_p, w_p, ar_p} = {e.aw, e.w, e.ar};
			end else if (exp_valid && ready_in) begin
				rec_w = 1'b0;
				{aw_p, w_p, ar_p} = 3'b000;
			end
		end
	end

endmodule

// ==== dv/ex_tb.sv ====
`timescale 1ns/1ps

module ex_tb
	import ex_pkg::*;
();

	logic			clk = 0, reset, flush, valid_in, ready_out, valid_out, ready_in;
	logic	[31:0]	pc_id, imm_id, rs1_data_id, rs2_data_id, rd_data_mem;
	logic			rs1_rena_id, rs2_rena_id, rd_wena_id, rd_wena_mem;
	logic	[4:0]	rs1_addr_id, rs2_addr_id, rd_addr_id, rd_addr_mem;
	logic			sel_pc_id, sel_imm_id;
	wb_src_t		wb_src_id, wb_src_ex;
	alu_op_t		alu_op_id;
	mem_op_t		mem_op_id, mem_op_ex;
	mul_op_t		mul_op_id;
	logic			jump_ena_id, jump_ind_id, jump_alw_id, jump_pred_id;
	logic			rd_wena_ex, jump_taken_ex, jump_mpred_ex, exc_pend_ex;
	logic	[4:0]	rd_addr_ex;
	logic	[31:0]	pc_ex, rd_data_ex, jump_addr_ex, exc_cause_ex;
	logic	[31:0]	axi_awaddr, axi_wdata, axi_araddr;
	logic	[2:0]	axi_awprot, axi_arprot;
	logic	[3:0]	axi_wstrb;
	logic			axi_awvalid, axi_awready, axi_wvalid, axi_wready;
	logic			axi_arvalid, axi_arready;
	int				errors;
	int				timeouts = 0;

	ex_stage #(.XLEN(32), .DIGIT(8)) u_ex_stage (.*);
	ex_checker u_checker (.*);

	always #20 clk = ~clk;

	// memory side back-pressure and MEM forwarding
	always @(posedge clk) begin
		ready_in <= ($urandom % 4) != 0;
		axi_awready <= $urandom % 2;
		axi_wready <= $urandom % 2;
		axi_arready <= $urandom % 2;
		rd_wena_mem <= $urandom % 2;
		rd_addr_mem <= $urandom % 8;
		rd_data_mem <= $urandom;
	end

	task automatic clear_fields();
		{pc_id, imm_id, rs1_data_id, rs2_data_id} <= '0;
		{rs1_rena_id, rs2_rena_id, rd_wena_id, sel_pc_id, sel_imm_id} <= '0;
		{rs1_addr_id, rs2_addr_id, rd_addr_id} <= '0;
		{jump_ena_id, jump_ind_id, jump_alw_id, jump_pred_id} <= '0;
		wb_src_id <= SEL_ALU;
		alu_op_id <= ALU_ADD;
		mem_op_id <= MEM_LB;
		mul_op_id <= MUL_MUL;
	endtask

	task automatic issue();
		int n;
		logic got;
		got = 1'b0;
		n = 0;
		valid_in <= 1'b1;
		while (!got && n < 200) begin
			@(negedge clk);
			got = ready_out;
			@(posedge clk);
			n++;
		end
		valid_in <= 1'b0;
		if (!got) begin
			timeouts++;
			$display("timeout waiting for ready_out to accept an instruction");
		end
	endtask

	task automatic alu_rand();
		clear_fields();
		alu_op_id <= alu_op_t'($urandom % 10);
		{rs1_rena_id, rs2_rena_id, rd_wena_id} <= 3'b111;
		rs1_addr_id <= $urandom % 8;
		rs2_addr_id <= $urandom % 8;
		rd_addr_id <= $urandom % 8;
		rs1_data_id <= $urandom;
		rs2_data_id <= $urandom;
		sel_imm_id <= $urandom % 2;
		imm_id <= $urandom;
		issue();
	endtask

	// register file operands only, so the start-cycle values hold
	task automatic mul_rand();
		clear_fields();
		wb_src_id <= SEL_MUL;
		mul_op_id <= mul_op_t'($urandom % 4);
		rs1_data_id <= $urandom;
		rs2_data_id <= $urandom;
		rd_wena_id <= 1'b1;
		rd_addr_id <= $urandom % 8;
		issue();
	endtask

	task automatic jump_rand();
		int kind;
		kind = $urandom % 3;
		clear_fields();
		jump_ena_id <= 1'b1;
		jump_pred_id <= $urandom % 2;
		pc_id <= $urandom & 32'hffff_fffc;
		imm_id <= 32'((int'($urandom % 128) - 64) * 2);
		{rs1_rena_id, rs2_rena_id} <= 2'b11;
		rs1_addr_id <= $urandom % 8;
		rs2_addr_id <= $urandom % 8;
		rs1_data_id <= (kind == 2) ? $urandom : $urandom % 4;
		rs2_data_id <= $urandom % 4;
		if (kind == 0) begin
			alu_op_id <= alu_op_t'(10 + $urandom % 6);
		end else begin
			jump_alw_id <= 1'b1;
			jump_ind_id <= (kind == 2);
			wb_src_id <= SEL_PC4;
			rd_wena_id <= 1'b1;
			rd_addr_id <= $urandom % 8;
		end
		issue();
	endtask

	task automatic mem_rand();
		int op;
		op = $urandom % 8;
		clear_fields();
		wb_src_id <= SEL_MEM;
		mem_op_id <= mem_op_t'(op);
		{rs1_rena_id, rs2_rena_id, sel_imm_id} <= 3'b111;
		rs1_addr_id <= $urandom % 8;
		rs2_addr_id <= $urandom % 8;
		rs1_data_id <= $urandom;
		rs2_data_id <= $urandom;
		imm_id <= $urandom % 16;
		rd_wena_id <= (op < 5);
		rd_addr_id <= $urandom % 8;
		issue();
	endtask

	// flush lands in the cycle the instruction sits in EX
	task automatic flush_in_flight();
		mem_rand();
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	initial begin
		int n;
		void'($urandom(83484));
		{reset, flush, valid_in} = 3'b100;
		{ready_in, axi_awready, axi_wready, axi_arready} = '0;
		{rd_wena_mem, rd_addr_mem, rd_data_mem} = '0;
		clear_fields();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		repeat (60) alu_rand();
		repeat (30) mul_rand();
		repeat (40) jump_rand();
		repeat (40) mem_rand();
		repeat (200) begin
			case ($urandom % 4)
				0: alu_rand();
				1: mul_rand();
				2: jump_rand();
				default: mem_rand();
			endcase
		end
		// aligned load then a dependent ALU op
		clear_fields();
		wb_src_id <= SEL_MEM;
		mem_op_id <= MEM_LW;
		{rd_wena_id, rd_addr_id} <= {1'b1, 5'd5};
		{sel_imm_id, imm_id} <= {1'b1, 32'h100};
		issue();
		clear_fields();
		{rs1_rena_id, rs1_addr_id, rd_wena_id, rd_addr_id} <= {1'b1, 5'd5, 1'b1, 5'd6};
		issue();
		repeat (5) flush_in_flight();
		n = 0;
		while (valid_out && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (valid_out) begin
			timeouts++;
			$display("timeout waiting for the last result to leave EX");
		end
		repeat (3) @(posedge clk);
		$display("checker errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu
	import ex_pkg::*;
#(
	parameter int XLEN = 32
) (
	input	alu_op_t			op,
	input	logic	[XLEN-1:0]	a,
	input	logic	[XLEN-1:0]	b,
	output	logic	[XLEN-1:0]	y
);

	localparam int SHW = $clog2(XLEN);

	logic	[SHW-1:0]	shamt;

	assign shamt = b[SHW-1:0];

	always_comb begin
		case (op)
			ALU_ADD:	y = a + b;
			ALU_SUB:	y = a - b;
			ALU_SLL:	y = a << shamt;
			ALU_SRL:	y = a >> shamt;
			ALU_SRA:	y = $unsigned($signed(a) >>> shamt);
			ALU_XOR:	y = a ^ b;
			ALU_OR:		y = a | b;
			ALU_AND:	y = a & b;
			// compares leave the flag in bit 0
			ALU_SLT,
			ALU_LT:		y = XLEN'($signed(a) < $signed(b));
			ALU_SLTU,
			ALU_LTU:	y = XLEN'(a < b);
			ALU_GE:		y = XLEN'($signed(a) >= $signed(b));
			ALU_GEU:	y = XLEN'(a >= b);
			ALU_EQ:		y = XLEN'(a == b);
			ALU_NE:		y = XLEN'(a != b);
			default:	y = '0;
		endcase
	end

endmodule

// ==== src/ex_bypass.sv ====
`timescale 1ns/1ps

module ex_bypass
	import ex_pkg::*;
#(
	parameter int XLEN = 32
) (
	input	logic				rs1_rena,
	input	logic	[4:0]		rs1_addr,
	input	logic	[XLEN-1:0]	rs1_data,
	input	logic				rs2_rena,
	input	logic	[4:0]		rs2_addr,
	input	logic	[XLEN-1:0]	rs2_data,
	input	logic				rd_wena_ex,
	input	logic	[4:0]		rd_addr_ex,
	input	logic	[XLEN-1:0]	rd_data_ex,
	input	wb_src_t			wb_src_ex,
	input	logic				rd_wena_mem,
	input	logic	[4:0]		rd_addr_mem,
	input	logic	[XLEN-1:0]	rd_data_mem,
	output	logic	[XLEN-1:0]	rs1_fwd,
	output	logic	[XLEN-1:0]	rs2_fwd,
	output	logic				load_use
);

	logic	rs1_hit_ex;
	logic	rs1_hit_mem;
	logic	rs2_hit_ex;
	logic	rs2_hit_mem;

	// x0 never forwards
	function automatic logic hit(
		input logic			rena,
		input logic	[4:0]	src,
		input logic			wena,
		input logic	[4:0]	dst
	);
		return rena && (src != 5'd0) && wena && (src == dst);
	endfunction

	assign rs1_hit_ex  = hit(rs1_rena, rs1_addr, rd_wena_ex, rd_addr_ex);
	assign rs1_hit_mem = hit(rs1_rena, rs1_addr, rd_wena_mem, rd_addr_mem);
	assign rs2_hit_ex  = hit(rs2_rena, rs2_addr, rd_wena_ex, rd_addr_ex);
	assign rs2_hit_mem = hit(rs2_rena, rs2_addr, rd_wena_mem, rd_addr_mem);

	// youngest result wins
	assign rs1_fwd = rs1_hit_ex ? rd_data_ex : rs1_hit_mem ? rd_data_mem : rs1_data;
	assign rs2_fwd = rs2_hit_ex ? rd_data_ex : rs2_hit_mem ? rd_data_mem : rs2_data;

	// load data is not there until MEM
	assign load_use = (rs1_hit_ex || rs2_hit_ex) && (wb_src_ex == SEL_MEM);

endmodule

// ==== src/ex_pkg.sv ====
package ex_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU
	} alu_op_t;

	typedef enum logic [1:0] {
		MUL_MUL,
		MUL_MULH,
		MUL_MULHSU,
		MUL_MULHU
	} mul_op_t;

	// SEL_PC4 carries the link value of jumps
	typedef enum logic [2:0] {
		SEL_ALU,
		SEL_MEM,
		SEL_MUL,
		SEL_PC4
	} wb_src_t;

	typedef enum logic [2:0] {
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} mul_state_t;

	localparam logic [31:0] CAUSE_MISALIGNED_INST  = 32'd0;
	localparam logic [31:0] CAUSE_MISALIGNED_LOAD  = 32'd4;
	localparam logic [31:0] CAUSE_MISALIGNED_STORE = 32'd6;

endpackage

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage
	import ex_pkg::*;
#(
	parameter int XLEN  = 32,
	parameter int DIGIT = 8
) (
	input	logic					clk,
	input	logic					reset,
	input	logic					flush,
	input	logic					valid_in,
	output	logic					ready_out,
	output	logic					valid_out,
	input	logic					ready_in,
	input	logic	[XLEN-1:0]		pc_id,
	input	logic	[XLEN-1:0]		imm_id,
	input	logic					rs1_rena_id,
	input	logic	[4:0]			rs1_addr_id,
	input	logic	[XLEN-1:0]		rs1_data_id,
	input	logic					rs2_rena_id,
	input	logic	[4:0]			rs2_addr_id,
	input	logic	[XLEN-1:0]		rs2_data_id,
	input	logic					rd_wena_id,
	input	logic	[4:0]			rd_addr_id,
	input	logic					sel_pc_id,
	input	logic					sel_imm_id,
	input	wb_src_t				wb_src_id,
	input	alu_op_t				alu_op_id,
	input	mem_op_t				mem_op_id,
	input	mul_op_t				mul_op_id,
	input	logic					jump_ena_id,
	input	logic					jump_ind_id,
	input	logic					jump_alw_id,
	input	logic					jump_pred_id,
	input	logic					rd_wena_mem,
	input	logic	[4:0]			rd_addr_mem,
	input	logic	[XLEN-1:0]		rd_data_mem,
	output	logic	[XLEN-1:0]		pc_ex,
	output	logic					rd_wena_ex,
	output	logic	[4:0]			rd_addr_ex,
	output	logic	[XLEN-1:0]		rd_data_ex,
	output	wb_src_t				wb_src_ex,
	output	mem_op_t				mem_op_ex,
	output	logic					jump_taken_ex,
	output	logic					jump_mpred_ex,
	output	logic	[XLEN-1:0]		jump_addr_ex,
	output	logic					exc_pend_ex,
	output	logic	[31:0]			exc_cause_ex,
	output	logic	[XLEN-1:0]		axi_awaddr,
	output	logic	[2:0]			axi_awprot,
	output	logic					axi_awvalid,
	input	logic					axi_awready,
	output	logic	[XLEN-1:0]		axi_wdata,
	output	logic	[XLEN/8-1:0]	axi_wstrb,
	output	logic					axi_wvalid,
	input	logic					axi_wready,
	output	logic	[XLEN-1:0]		axi_araddr,
	output	logic	[2:0]			axi_arprot,
	output	logic					axi_arvalid,
	input	logic					axi_arready
);

	localparam int NB = XLEN / 8;
	localparam int AW = $clog2(NB);

	logic	[XLEN-1:0]	rs1_fwd;
	logic	[XLEN-1:0]	rs2_fwd;
	logic				load_use;
	logic	[XLEN-1:0]	op_a;
	logic	[XLEN-1:0]	op_b;
	logic	[XLEN-1:0]	alu_out;
	logic	[XLEN-1:0]	pc_plus4;
	logic				jump_taken;
	logic				jump_mpred;
	logic	[XLEN-1:0]	jump_addr;
	logic				is_mem;
	logic				is_store;
	logic				mis_inst;
	logic				mis_load;
	logic				mis_store;
	logic				exc_pend;
	logic	[31:0]		exc_cause;
	logic	[XLEN-1:0]	st_data;
	logic	[NB-1:0]	st_strb;
	logic				mul_wait;
	logic				mul_started;
	logic				accept;
	logic				leave;
	logic				valid_q;
	logic				aw_pend;
	logic				w_pend;
	logic				ar_pend;

	mul_if #(.XLEN(XLEN)) mul_bus ();

	ex_bypass #(.XLEN(XLEN)) u_bypass (
		.rs1_rena    (rs1_rena_id),
		.rs1_addr    (rs1_addr_id),
		.rs1_data    (rs1_data_id),
		.rs2_rena    (rs2_rena_id),
		.rs2_addr    (rs2_addr_id),
		.rs2_data    (rs2_data_id),
		.rd_wena_ex  (rd_wena_ex),
		.rd_addr_ex  (rd_addr_ex),
		.rd_data_ex  (rd_data_ex),
		.wb_src_ex   (wb_src_ex),
		.rd_wena_mem (rd_wena_mem),
		.rd_addr_mem (rd_addr_mem),
		.rd_data_mem (rd_data_mem),
		.rs1_fwd     (rs1_fwd),
		.rs2_fwd     (rs2_fwd),
		.load_use    (load_use)
	);

	assign op_a = sel_pc_id ? pc_id : rs1_fwd;
	assign op_b = sel_imm_id ? imm_id : rs2_fwd;

	alu #(.XLEN(XLEN)) u_alu (
		.op (alu_op_id),
		.a  (op_a),
		.b  (op_b),
		.y  (alu_out)
	);

	int_multiplier #(.XLEN(XLEN), .DIGIT(DIGIT)) u_mul (
		.clk   (clk),
		.reset (reset),
		.flush (flush),
		.m     (mul_bus.mul)
	);

	// one start pulse per multiply, only once operands are final
	assign mul_bus.start = valid_in && wb_src_id == SEL_MUL && !mul_bus.busy
		&& !mul_bus.done && !mul_started && !load_use && !flush;
	assign mul_bus.op    = mul_op_id;
	assign mul_bus.a     = op_a;
	assign mul_bus.b     = op_b;
	assign mul_bus.take  = accept;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			mul_started <= 1'b0;
		else if (flush || accept)
			mul_started <= 1'b0;
		else if (mul_bus.start)
			mul_started <= 1'b1;
	end

	assign mul_wait  = valid_in && wb_src_id == SEL_MUL && !mul_bus.done;
	assign leave     = valid_q && ready_in;
	assign ready_out = !(load_use || mul_wait || (valid_q && !ready_in));
	assign accept    = valid_in && ready_out;

	// branch and jump resolution
	assign pc_plus4   = pc_id + XLEN'(4);
	assign jump_taken = jump_ena_id && (alu_out[0] || jump_alw_id);
	assign jump_mpred = jump_ena_id && (jump_pred_id != jump_taken);

	always_comb begin
		if (!jump_taken)
			jump_addr = pc_plus4;
		else if (jump_ind_id)
			jump_addr = (rs1_fwd + imm_id) & {{(XLEN-1){1'b1}}, 1'b0};
		else
			jump_addr = pc_id + imm_id;
	end

	assign is_mem   = (wb_src_id == SEL_MEM);
	assign is_store = mem_op_id inside {MEM_SB, MEM_SH, MEM_SW};
	assign mis_inst = jump_taken && |jump_addr[1:0];

	always_comb begin
		mis_load  = 1'b0;
		mis_store = 1'b0;
		if (is_mem) begin
			case (mem_op_id)
				MEM_LH,
				MEM_LHU:	mis_load  = alu_out[0];
				MEM_LW:		mis_load  = |alu_out[1:0];
				MEM_SH:		mis_store = alu_out[0];
				MEM_SW:		mis_store = |alu_out[1:0];
				default:	;
			endcase
		end
	end

	always_comb begin
		exc_pend = 1'b1;
		if (mis_inst) begin
			exc_cause = CAUSE_MISALIGNED_INST;
		end else if (mis_load) begin
			exc_cause = CAUSE_MISALIGNED_LOAD;
		end else if (mis_store) begin
			exc_cause = CAUSE_MISALIGNED_STORE;
		end else begin
			exc_pend  = 1'b0;
			exc_cause = '0;
		end
	end

	// store data replicated over all lanes
	always_comb begin
		st_data = '0;
		st_strb = '0;
		case (mem_op_id)
			MEM_SB: begin
				st_data = {NB{rs2_fwd[7:0]}};
				st_strb = NB'(1) << alu_out[AW-1:0];
			end
			MEM_SH: begin
				st_data = {(NB/2){rs2_fwd[15:0]}};
				st_strb = NB'(3) << alu_out[AW-1:0];
			end
			MEM_SW: begin
				st_data = {(NB/4){rs2_fwd[31:0]}};
				st_strb = NB'(15) << alu_out[AW-1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q       <= 1'b0;
			rd_wena_ex    <= 1'b0;
			jump_taken_ex <= 1'b0;
			jump_mpred_ex <= 1'b0;
			exc_pend_ex   <= 1'b0;
			aw_pend       <= 1'b0;
			w_pend        <= 1'b0;
			ar_pend       <= 1'b0;
		end else if (flush || (leave && !accept)) begin
			valid_q       <= 1'b0;
			rd_wena_ex    <= 1'b0;
			jump_taken_ex <= 1'b0;
			jump_mpred_ex <= 1'b0;
			exc_pend_ex   <= 1'b0;
			aw_pend       <= 1'b0;
			w_pend        <= 1'b0;
			ar_pend       <= 1'b0;
		end else if (accept) begin
			valid_q       <= 1'b1;
			rd_wena_ex    <= rd_wena_id && !exc_pend;
			jump_taken_ex <= jump_taken;
			jump_mpred_ex <= jump_mpred;
			exc_pend_ex   <= exc_pend;
			aw_pend       <= is_mem && is_store && !exc_pend;
			w_pend        <= is_mem && is_store && !exc_pend;
			ar_pend       <= is_mem && !is_store && !exc_pend;
		end else begin
			// each channel drops on its own handshake
			if (axi_awvalid && axi_awready)
				aw_pend <= 1'b0;
			if (axi_wvalid && axi_wready)
				w_pend <= 1'b0;
			if (axi_arvalid && axi_arready)
				ar_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_ex        <= pc_id;
			rd_addr_ex   <= rd_addr_id;
			wb_src_ex    <= wb_src_id;
			mem_op_ex    <= mem_op_id;
			jump_addr_ex <= jump_addr;
			exc_cause_ex <= exc_cause;
			axi_awaddr   <= alu_out;
			axi_araddr   <= alu_out;
			axi_wdata    <= st_data;
			axi_wstrb    <= st_strb;
			case (wb_src_id)
				SEL_MUL: rd_data_ex <= mul_bus.result;
				SEL_PC4: rd_data_ex <= pc_plus4;
				default: rd_data_ex <= alu_out;
			endcase
		end
	end

	// data access, unprivileged
	assign axi_awprot = 3'b010;
	assign axi_arprot = 3'b010;

	assign valid_out   = valid_q && !flush;
	assign axi_awvalid = aw_pend && valid_out;
	assign axi_wvalid  = w_pend && valid_out;
	assign axi_arvalid = ar_pend && valid_out;

endmodule

// ==== src/int_multiplier.sv ====
`timescale 1ns/1ps

module int_multiplier
	import ex_pkg::*;
#(
	parameter int XLEN  = 32,
	parameter int DIGIT = 8
) (
	input	logic	clk,
	input	logic	reset,
	input	logic	flush,
	mul_if.mul		m
);

	localparam int STEPS = XLEN / DIGIT;
	localparam int CW    = $clog2(STEPS + 1);

	mul_state_t					state;
	logic	[CW-1:0]			count;
	mul_op_t					op_q;
	logic						neg_q;
	logic	[XLEN-1:0]			mag_a;
	logic	[2*XLEN-1:0]		prod;

	logic						a_neg;
	logic						b_neg;
	logic	[XLEN+DIGIT-1:0]	step_sum;
	logic	[2*XLEN-1:0]		prod_fix;

	// a is signed for MULH and MULHSU, b only for MULH
	assign a_neg = (m.op == MUL_MULH || m.op == MUL_MULHSU) && m.a[XLEN-1];
	assign b_neg = (m.op == MUL_MULH) && m.b[XLEN-1];

	// low digit of b times |a| into the upper half
	assign step_sum = {{DIGIT{1'b0}}, prod[2*XLEN-1:XLEN]}
		+ {{DIGIT{1'b0}}, mag_a} * {{XLEN{1'b0}}, prod[DIGIT-1:0]};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
		end else if (flush) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (m.start) begin
						state <= RUN;
						count <= '0;
					end
				end
				RUN: begin
					count <= count + 1'b1;
					if (count == CW'(STEPS - 1))
						state <= DONE;
				end
				DONE: begin
					if (m.take)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && m.start) begin
			op_q  <= m.op;
			neg_q <= a_neg ^ b_neg;
			mag_a <= a_neg ? -m.a : m.a;
			prod  <= {{XLEN{1'b0}}, (b_neg ? -m.b : m.b)};
		end else if (state == RUN) begin
			prod <= {step_sum, prod[XLEN-1:DIGIT]};
		end
	end

	assign prod_fix = neg_q ? -prod : prod;

	assign m.result = (op_q == MUL_MUL) ? prod_fix[XLEN-1:0] : prod_fix[2*XLEN-1:XLEN];
	assign m.busy   = (state == RUN);
	assign m.done   = (state == DONE);

endmodule

// ==== src/mul_if.sv ====
`timescale 1ns/1ps

interface mul_if
	import ex_pkg::*;
#(
	parameter int XLEN = 32
) ();

	logic				start;
	mul_op_t			op;
	logic	[XLEN-1:0]	a;
	logic	[XLEN-1:0]	b;
	logic				busy;
	logic				done;
	logic	[XLEN-1:0]	result;
	logic				take;

	modport stage (
		output	start, op, a, b, take,
		input	busy, done, result
	);

	modport mul (
		input	start, op, a, b, take,
		output	busy, done, result
	);

endinterface

// ==== tb.f ====
src/ex_pkg.sv
src/mul_if.sv
src/alu.sv
src/int_multiplier.sv
src/ex_bypass.sv
src/ex_stage.sv
dv/ex_checker.sv
dv/ex_tb.sv
